//--- bench/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

   ////////////////////////////////////////
   // constants
   ////////////////////////////////////////
   localparam int NUM_TESTS  = 6;
   localparam int MAX_CYCLES = NUM_TESTS * 200;   // whole run, reset cycles included

   // mips encodings, opcode field
   localparam logic [5:0] OPC_J     = 6'h02;
   localparam logic [5:0] OPC_BEQ   = 6'h04;
   localparam logic [5:0] OPC_BNE   = 6'h05;
   localparam logic [5:0] OPC_ADDIU = 6'h09;
   localparam logic [5:0] OPC_ORI   = 6'h0D;
   localparam logic [5:0] OPC_LUI   = 6'h0F;
   localparam logic [5:0] OPC_LW    = 6'h23;
   localparam logic [5:0] OPC_SW    = 6'h2B;
   // funct field of r-type
   localparam logic [5:0] FN_ADDU = 6'h21;
   localparam logic [5:0] FN_SUBU = 6'h23;
   localparam logic [5:0] FN_AND  = 6'h24;
   localparam logic [5:0] FN_OR   = 6'h25;
   localparam logic [5:0] FN_SLT  = 6'h2A;
   localparam logic [31:0] HALT_WORD = {6'h3F, 26'd0};   // opcode all ones

   logic        clk;
   logic        rst;
   logic [31:0] imem_addr, imem_load;
   logic [31:0] dmem_addr, dmem_store, dmem_load;
   logic        dmem_ren, dmem_wen, halt;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   int          prog_len;
   int          cycle_count = 0;
   int          error_count = 0;
   int          ren_cycles  = 0;   // cycles with dmem_ren_o high
   logic [31:0] lcg_state = 32'd40;   // seed
   string       test_name;

   cpu_core #(.PC_INIT(32'h0)) dut0 (
      .CLK(clk), .rst_i(rst),
      .imem_addr_o(imem_addr), .imem_load_i(imem_load),
      .dmem_addr_o(dmem_addr), .dmem_ren_o(dmem_ren), .dmem_wen_o(dmem_wen),
      .dmem_store_o(dmem_store), .dmem_load_i(dmem_load),
      .halt_o(halt)
   );

   ////////////////////////////////////////
   // memory models, clock, watchdogs
   ////////////////////////////////////////
   assign imem_load = imem[imem_addr[9:2]];   // comb read, word addressed
   assign dmem_load = dmem[dmem_addr[9:2]];

   always @(posedge clk) begin
      if (dmem_wen) dmem[dmem_addr[9:2]] <= dmem_store;   // write lands at edge
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES)
         abort_run("timeout: a program did not reach halt within the cycle limit");
   end

   // sampled mid-cycle, both levels stable
   always @(negedge clk) begin
      if (halt === 1'b1 && dmem_wen === 1'b1)
         abort_run("data memory write seen after halt_o had risen");
   end

   always @(negedge clk) begin
      if (dmem_ren === 1'b1) ren_cycles++;   // one per load, in its memory cycle
   end

   ////////////////////////////////////////
   // helpers
   ////////////////////////////////////////
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_equal(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         error_count++;
         abort_run($sformatf("[ERROR] %s %s: expected %08h, actual %08h",
                             test_name, what, expected, actual));
      end
   endtask

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;   // numerical recipes lcg
      return lcg_state;
   endfunction

   // every address bit shows up in the word
   function automatic logic [31:0] fill_value(input logic [31:0] addr);
      return addr ^ 32'h5A5A_0000;
   endfunction

   function automatic logic [31:0] read_data(input logic [31:0] addr);
      return dmem[addr[9:2]];
   endfunction

   function automatic logic [31:0] r_instr(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd);
      return {6'd0, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] j_instr(input logic [25:0] target);
      return {OPC_J, target};   // word index, pc_init is zero
   endfunction

   task automatic emit(input logic [31:0] word);
      imem[prog_len[7:0]] = word;
      prog_len++;
   endtask

   task automatic clear_memories();
      for (int i = 0; i < 256; i++) begin
         imem[i[7:0]] = '0;                    // no-ops past the program
         dmem[i[7:0]] <= fill_value(i * 4);
      end
   endtask

   // reset goes high first so a halted core cannot run the new image
   task automatic begin_test(input string name);
      test_name = name;
      @(posedge clk);
      #1 rst = 1'b1;
      @(posedge clk);
      #1;
      clear_memories();
      prog_len   = 0;
      ren_cycles = 0;
   endtask

   // finish the 5-cycle reset, run to halt_o, then watch it stay high
   task automatic run_program(output int edges);
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;
      check_equal("halt_o after reset", 32'd0, {31'd0, halt});
      check_equal("dmem_wen_o after reset", 32'd0, {31'd0, dmem_wen});
      check_equal("dmem_ren_o after reset", 32'd0, {31'd0, dmem_ren});
      edges = 0;
      do begin
         @(posedge clk);
         #1 edges++;
      end while (halt !== 1'b1);
      repeat (8) begin
         @(posedge clk);
         #1 check_equal("halt_o held", 32'd1, {31'd0, halt});
      end
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic test_forwarding();
      logic [31:0] a, b, c, d, e, f;
      int          edges;
      begin_test("forwarding");
      a = 32'h0000_1234;
      b = 32'hFFFF_FFFD;                           // -3 after sign extension
      emit(i_instr(OPC_ADDIU, 0, 1, a[15:0]));
      emit(i_instr(OPC_ADDIU, 0, 2, b[15:0]));
      emit(r_instr(FN_ADDU, 1, 2, 3));             // r2 from mem, r1 from wb
      emit(r_instr(FN_SUBU, 3, 1, 4));             // r3 from mem
      emit(r_instr(FN_OR,   4, 3, 5));             // r4 mem, r3 wb
      emit(r_instr(FN_AND,  5, 4, 6));             // r5 mem, r4 wb
      emit(i_instr(OPC_SW, 0, 6, 16'h0100));       // store data via mem
      emit(i_instr(OPC_SW, 0, 5, 16'h0104));       // store data via rf bypass
      emit(i_instr(OPC_SW, 0, 3, 16'h0108));
      emit(i_instr(OPC_SW, 0, 4, 16'h010C));
      emit(HALT_WORD);
      run_program(edges);
      c = a + b;
      d = c - a;
      e = d | c;
      f = e & d;
      check_equal("and result", f, read_data(32'h100));
      check_equal("or result", e, read_data(32'h104));
      check_equal("addu result", c, read_data(32'h108));
      check_equal("subu result", d, read_data(32'h10C));
   endtask

   task automatic test_load_use();
      logic [31:0] v;
      int          edges;
      begin_test("load_use");
      v = next_rand();
      dmem[8'h48] <= v;                            // word at 0x120
      emit(i_instr(OPC_ADDIU, 0, 7, 16'hFF00));
      emit(i_instr(OPC_LW, 0, 1, 16'h0120));
      emit(r_instr(FN_ADDU, 1, 7, 2));             // bubble, then r1 from wb
      emit(i_instr(OPC_SW, 0, 2, 16'h0124));
      emit(i_instr(OPC_LW, 0, 3, 16'h0120));
      emit(i_instr(OPC_SW, 0, 3, 16'h0128));       // load feeds store data
      emit(HALT_WORD);
      run_program(edges);
      check_equal("load plus constant", v + 32'hFFFF_FF00, read_data(32'h124));
      check_equal("loaded word stored", v, read_data(32'h128));
      check_equal("dmem_ren_o cycles", 32'd2, ren_cycles);   // two loads
   endtask

   task automatic test_branches();
      int edges;
      begin_test("branches");
      emit(i_instr(OPC_ADDIU, 0, 1, 16'd9));
      emit(i_instr(OPC_ADDIU, 0, 2, 16'd9));
      emit(i_instr(OPC_ADDIU, 0, 3, 16'd1));       // marker value
      emit(i_instr(OPC_BEQ, 1, 2, 16'd2));         // taken
      emit(i_instr(OPC_SW, 0, 3, 16'h0140));
      emit(i_instr(OPC_SW, 0, 3, 16'h0144));
      emit(i_instr(OPC_BNE, 1, 2, 16'd2));         // not taken
      emit(i_instr(OPC_SW, 0, 3, 16'h0148));
      emit(i_instr(OPC_SW, 0, 3, 16'h014C));
      emit(i_instr(OPC_BEQ, 1, 3, 16'd1));         // not taken
      emit(i_instr(OPC_SW, 0, 1, 16'h0150));
      emit(i_instr(OPC_BNE, 1, 3, 16'd2));         // taken
      emit(i_instr(OPC_SW, 0, 3, 16'h0154));
      emit(i_instr(OPC_SW, 0, 3, 16'h0158));
      emit(i_instr(OPC_SW, 0, 2, 16'h015C));       // bne target
      emit(HALT_WORD);
      run_program(edges);
      check_equal("beq shadow 1", fill_value(32'h140), read_data(32'h140));
      check_equal("beq shadow 2", fill_value(32'h144), read_data(32'h144));
      check_equal("bne fall 1", 32'd1, read_data(32'h148));
      check_equal("bne fall 2", 32'd1, read_data(32'h14C));
      check_equal("beq fall", 32'd9, read_data(32'h150));
      check_equal("bne shadow 1", fill_value(32'h154), read_data(32'h154));
      check_equal("bne shadow 2", fill_value(32'h158), read_data(32'h158));
      check_equal("bne target", 32'd9, read_data(32'h15C));
   endtask

   task automatic test_jump();
      int edges;
      begin_test("jump");
      emit(i_instr(OPC_ADDIU, 0, 1, 16'h0055));
      emit(j_instr(26'd3));
      emit(i_instr(OPC_SW, 0, 1, 16'h0160));       // skipped
      emit(i_instr(OPC_SW, 0, 1, 16'h0164));
      emit(HALT_WORD);
      run_program(edges);
      check_equal("skipped store", fill_value(32'h160), read_data(32'h160));
      check_equal("target store", 32'h55, read_data(32'h164));
   endtask

   task automatic test_random_ops();
      logic [31:0] x, y;
      logic [31:0] expect_val [1:8];
      logic [15:0] offset;
      int          edges;
      begin_test("random_ops");
      x = next_rand() | 32'h8000_0000;             // negative when signed
      y = next_rand() & 32'h7FFF_FFFF;             // so slt differs from sltu
      emit(i_instr(OPC_LUI, 0, 1, x[31:16]));
      emit(i_instr(OPC_ORI, 1, 1, x[15:0]));
      emit(i_instr(OPC_LUI, 0, 2, y[31:16]));
      emit(i_instr(OPC_ORI, 2, 2, y[15:0]));
      emit(r_instr(FN_ADDU, 1, 2, 3));
      emit(r_instr(FN_SUBU, 1, 2, 4));
      emit(r_instr(FN_AND,  1, 2, 5));
      emit(r_instr(FN_OR,   1, 2, 6));
      emit(r_instr(FN_SLT,  1, 2, 7));
      emit(r_instr(FN_SLT,  2, 1, 8));
      offset = 16'h0180;
      for (int r = 1; r <= 8; r++) begin
         emit(i_instr(OPC_SW, 0, r[4:0], offset));
         offset = offset + 16'd4;
      end
      emit(HALT_WORD);
      run_program(edges);
      expect_val[1] = x;
      expect_val[2] = y;
      expect_val[3] = x + y;
      expect_val[4] = x - y;
      expect_val[5] = x & y;
      expect_val[6] = x | y;
      expect_val[7] = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      expect_val[8] = ($signed(y) < $signed(x)) ? 32'd1 : 32'd0;
      for (int r = 1; r <= 8; r++)
         check_equal($sformatf("r%0d", r), expect_val[r], read_data(32'h180 + (r - 1) * 4));
   endtask

   task automatic test_halt();
      int edges;
      begin_test("halt");
      emit(i_instr(OPC_ADDIU, 0, 1, 16'd3));
      emit(i_instr(OPC_SW, 0, 1, 16'h01C0));
      emit(HALT_WORD);                             // index 2
      run_program(edges);
      // fetched in cycle 2, memory cycle 5, flag at the edge after
      check_equal("edges to halt_o", 32'd6, edges);
      check_equal("last store", 32'd3, read_data(32'h1C0));
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial begin
      rst = 1'b1;
      prog_len = 0;
      clear_memories();
      test_forwarding();
      test_load_use();
      test_branches();
      test_jump();
      test_random_ops();
      test_halt();
      if (error_count == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         $display("TB FAILED");
         $fatal(1, "checks failed");
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the cpu_core testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   -f sim.f --top-module tb_cpu_core -Mdir obj_dir -o tb_cpu_core
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/tb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
   echo "simulation reported failure"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
   echo "no pass line in $LOG"
   exit 1
fi
echo "simulation passed"
exit 0

//--- sim.f
source/cpu_pkg.sv
source/pipe_ctl_if.sv
source/pipe_latch.sv
source/fetch_unit.sv
source/decode_stage.sv
source/forward_unit.sv
source/execute_stage.sv
source/mem_access.sv
source/cpu_core.sv
bench/tb_cpu_core.sv

//--- source/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
   parameter word_t PC_INIT = '0
) (
   input  logic  CLK,
   input  logic  rst_i,
   output word_t imem_addr_o,
   input  word_t imem_load_i,
   output word_t dmem_addr_o,
   output logic  dmem_ren_o,
   output logic  dmem_wen_o,
   output word_t dmem_store_o,
   input  word_t dmem_load_i,
   output logic  halt_o
);

   pipe_ctl_if ctl_if ();

   ifid_t    ifid_d, ifid_q;
   idex_t    idex_d, idex_q;
   exmem_t   exmem_d, exmem_q;
   logic     ifid_hold, ifid_flush, idex_flush;
   regbits_t ifid_rs, ifid_rt;
   fwd_sel_t sel_a, sel_b;
   logic     wb_regw;
   regbits_t wb_dest;
   word_t    wb_data;

   ////////////////////////////////////////
   // fetch and front latches
   ////////////////////////////////////////
   fetch_unit #(.PC_INIT(PC_INIT)) fetch0 (
      .CLK, .rst_i, .ctl(ctl_if.fetch),
      .imem_addr_o, .imem_load_i,
      .ifid_o(ifid_d), .ifid_hold_o(ifid_hold),
      .ifid_flush_o(ifid_flush), .idex_flush_o(idex_flush)
   );

   pipe_latch #(.payload_t(ifid_t), .CAN_HOLD(1'b1), .CAN_FLUSH(1'b1)) ifid0 (
      .CLK, .rst_i, .hold_i(ifid_hold), .flush_i(ifid_flush), .d_i(ifid_d), .q_o(ifid_q)
   );

   decode_stage decode0 (
      .CLK, .rst_i, .ifid_i(ifid_q), .ctl(ctl_if.decode),
      .wb_regw_i(wb_regw), .wb_dest_i(wb_dest), .wb_data_i(wb_data),
      .idex_o(idex_d), .ifid_rs_o(ifid_rs), .ifid_rt_o(ifid_rt)
   );

   // id/ex flushes only, bubbles on stall
   pipe_latch #(.payload_t(idex_t), .CAN_HOLD(1'b0), .CAN_FLUSH(1'b1)) idex0 (
      .CLK, .rst_i, .hold_i(), .flush_i(idex_flush), .d_i(idex_d), .q_o(idex_q)
   );

   ////////////////////////////////////////
   // execute, memory, writeback
   ////////////////////////////////////////
   forward_unit fwd0 (
      .idex_i(idex_q), .ifid_rs_i(ifid_rs), .ifid_rt_i(ifid_rt),
      .mem_regw_i(exmem_q.regw), .mem_dest_i(exmem_q.dest),
      .wb_regw_i(wb_regw), .wb_dest_i(wb_dest),
      .ctl(ctl_if.hazard), .sel_a_o(sel_a), .sel_b_o(sel_b)
   );

   execute_stage exec0 (
      .idex_i(idex_q), .sel_a_i(sel_a), .sel_b_i(sel_b),
      .mem_result_i(exmem_q.result), .wb_data_i(wb_data),
      .ctl(ctl_if.execute), .exmem_o(exmem_d)
   );

   pipe_latch #(.payload_t(exmem_t), .CAN_HOLD(1'b0), .CAN_FLUSH(1'b0)) exmem0 (
      .CLK, .rst_i, .hold_i(), .flush_i(), .d_i(exmem_d), .q_o(exmem_q)
   );

   mem_access mem0 (
      .CLK, .rst_i, .exmem_i(exmem_q),
      .dmem_addr_o, .dmem_store_o, .dmem_ren_o, .dmem_wen_o, .dmem_load_i,
      .wb_regw_o(wb_regw), .wb_dest_o(wb_dest), .wb_data_o(wb_data),
      .halt_o
   );

endmodule

//--- source/cpu_pkg.sv
package cpu_pkg;

   typedef logic [31:0] word_t;     // data word or byte address
   typedef logic [4:0]  regbits_t;  // register index

   // major opcodes, instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'b000000,
      OP_J     = 6'b000010,
      OP_BEQ   = 6'b000100,
      OP_BNE   = 6'b000101,
      OP_ADDIU = 6'b001001,
      OP_ORI   = 6'b001101,
      OP_LUI   = 6'b001111,
      OP_LW    = 6'b100011,
      OP_SW    = 6'b101011,
      OP_HALT  = 6'b111111
   } opcode_t;

   // r-type functs, instr[5:0]
   typedef enum logic [5:0] {
      FN_ADDU = 6'b100001,
      FN_SUBU = 6'b100011,
      FN_AND  = 6'b100100,
      FN_OR   = 6'b100101,
      FN_SLT  = 6'b101010
   } funct_t;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} aluop_t;

   typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

   ////////////////////////////////////////
   // stage payloads
   ////////////////////////////////////////

   typedef struct packed {
      logic   regw;       // writes rf in wb
      logic   mem_read;
      logic   mem_write;
      logic   alu_imm;    // operand b from immediate
      aluop_t aluop;
      logic   beq;
      logic   bne;
      logic   halt;
   } ctrl_t;

   typedef struct packed {
      word_t instr;
      word_t pc4;
   } ifid_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    pc4;
      word_t    rdat1;
      word_t    rdat2;
      word_t    imm;      // already extended
      regbits_t rs;
      regbits_t rt;
      regbits_t dest;
   } idex_t;

   typedef struct packed {
      logic     regw;
      logic     mem_read;
      logic     mem_write;
      logic     halt;
      word_t    result;   // alu out, also dmem address
      word_t    store;    // forwarded rt value
      regbits_t dest;
   } exmem_t;

endpackage

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
   input  logic        CLK,
   input  logic        rst_i,
   input  ifid_t       ifid_i,
   pipe_ctl_if.decode  ctl,
   input  logic        wb_regw_i,
   input  regbits_t    wb_dest_i,
   input  word_t       wb_data_i,
   output idex_t       idex_o,
   output regbits_t    ifid_rs_o,
   output regbits_t    ifid_rt_o
);

   word_t       rf [32];
   opcode_t     op;
   funct_t      fn;
   regbits_t    rs, rt, rd;
   logic [15:0] imm16;
   ctrl_t       ctrl;
   regbits_t    dest;
   word_t       imm_ext;
   word_t       rdat1, rdat2;

   // instruction fields
   assign op    = opcode_t'(ifid_i.instr[31:26]);
   assign fn    = funct_t'(ifid_i.instr[5:0]);
   assign rs    = ifid_i.instr[25:21];
   assign rt    = ifid_i.instr[20:16];
   assign rd    = ifid_i.instr[15:11];
   assign imm16 = ifid_i.instr[15:0];

   ////////////////////////////////////////
   // control decode
   ////////////////////////////////////////
   always_comb begin
      ctrl = '0;
      dest = rt;                       // i-type writes rt
      case (op)
         OP_RTYPE: begin
            dest      = rd;
            ctrl.regw = 1'b1;
            case (fn)
               FN_ADDU: ctrl.aluop = ALU_ADD;
               FN_SUBU: ctrl.aluop = ALU_SUB;
               FN_AND:  ctrl.aluop = ALU_AND;
               FN_OR:   ctrl.aluop = ALU_OR;
               FN_SLT:  ctrl.aluop = ALU_SLT;
               default: ctrl.regw  = 1'b0;   // all-zero word lands here
            endcase
         end
         OP_ADDIU: begin
            ctrl.regw    = 1'b1;
            ctrl.alu_imm = 1'b1;
         end
         OP_ORI: begin
            ctrl.regw    = 1'b1;
            ctrl.alu_imm = 1'b1;
            ctrl.aluop   = ALU_OR;
         end
         OP_LUI: begin
            ctrl.regw    = 1'b1;
            ctrl.alu_imm = 1'b1;
            ctrl.aluop   = ALU_LUI;
         end
         OP_LW: begin
            ctrl.regw     = 1'b1;
            ctrl.mem_read = 1'b1;
            ctrl.alu_imm  = 1'b1;
         end
         OP_SW: begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_imm   = 1'b1;
         end
         OP_BEQ:  ctrl.beq  = 1'b1;
         OP_BNE:  ctrl.bne  = 1'b1;
         OP_HALT: ctrl.halt = 1'b1;
         default: ;                    // j and unknown words do nothing past here
      endcase
   end

   // zero-ext for ori, upper half for lui, sign-ext otherwise
   always_comb begin
      case (op)
         OP_ORI:  imm_ext = {16'h0000, imm16};
         OP_LUI:  imm_ext = {imm16, 16'h0000};
         default: imm_ext = {{16{imm16[15]}}, imm16};
      endcase
   end

   ////////////////////////////////////////
   // register file
   ////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst_i) begin
         for (int i = 0; i < 32; i++) rf[i] <= '0;
      end else if (wb_regw_i && (wb_dest_i != '0)) begin
         rf[wb_dest_i] <= wb_data_i;   // r0 never written
      end
   end

   // write-through so wb and decode can share a cycle
   always_comb begin
      rdat1 = rf[rs];
      rdat2 = rf[rt];
      if (wb_regw_i && (wb_dest_i != '0) && (wb_dest_i == rs)) rdat1 = wb_data_i;
      if (wb_regw_i && (wb_dest_i != '0) && (wb_dest_i == rt)) rdat2 = wb_data_i;
   end

   always_comb begin
      idex_o.ctrl  = ctrl;
      idex_o.pc4   = ifid_i.pc4;
      idex_o.rdat1 = rdat1;
      idex_o.rdat2 = rdat2;
      idex_o.imm   = imm_ext;
      idex_o.rs    = rs;
      idex_o.rt    = rt;
      idex_o.dest  = dest;
   end

   assign ifid_rs_o = rs;              // to load-use check
   assign ifid_rt_o = rt;

   // j redirect, pseudo-direct target
   assign ctl.jump_take = (op == OP_J);
   assign ctl.jump_pc   = {ifid_i.pc4[31:28], ifid_i.instr[25:0], 2'b00};

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  idex_t        idex_i,
   input  fwd_sel_t     sel_a_i,
   input  fwd_sel_t     sel_b_i,
   input  word_t        mem_result_i,   // ex/mem alu result
   input  word_t        wb_data_i,
   pipe_ctl_if.execute  ctl,
   output exmem_t       exmem_o
);

   word_t opa;
   word_t opb_reg;     // forwarded rt, also store data
   word_t opb;
   word_t result;
   logic  equal;

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                     input word_t mem_val, input word_t wb_val);
      case (sel)
         FWD_MEM: return mem_val;
         FWD_WB:  return wb_val;
         default: return reg_val;
      endcase
   endfunction

   assign opa     = fwd_mux(sel_a_i, idex_i.rdat1, mem_result_i, wb_data_i);
   assign opb_reg = fwd_mux(sel_b_i, idex_i.rdat2, mem_result_i, wb_data_i);
   assign opb     = idex_i.ctrl.alu_imm ? idex_i.imm : opb_reg;

   ////////////////////////////////////////
   // alu
   ////////////////////////////////////////
   always_comb begin
      case (idex_i.ctrl.aluop)
         ALU_ADD: result = opa + opb;
         ALU_SUB: result = opa - opb;
         ALU_AND: result = opa & opb;
         ALU_OR:  result = opa | opb;
         ALU_SLT: result = {31'd0, $signed(opa) < $signed(opb)};  // signed compare
         default: result = opb;        // lui, imm already in upper half
      endcase
   end

   // branch resolve
   assign equal           = (opa == opb_reg);
   assign ctl.branch_take = (idex_i.ctrl.beq & equal) | (idex_i.ctrl.bne & ~equal);
   assign ctl.branch_pc   = idex_i.pc4 + {idex_i.imm[29:0], 2'b00};

   always_comb begin
      exmem_o.regw      = idex_i.ctrl.regw;
      exmem_o.mem_read  = idex_i.ctrl.mem_read;
      exmem_o.mem_write = idex_i.ctrl.mem_write;
      exmem_o.halt      = idex_i.ctrl.halt;
      exmem_o.result    = result;
      exmem_o.store     = opb_reg;
      exmem_o.dest      = idex_i.dest;
   end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
   parameter word_t PC_INIT = '0
) (
   input  logic            CLK,
   input  logic            rst_i,
   pipe_ctl_if.fetch       ctl,
   output word_t           imem_addr_o,
   input  word_t           imem_load_i,
   output ifid_t           ifid_o,
   output logic            ifid_hold_o,
   output logic            ifid_flush_o,
   output logic            idex_flush_o
);

   word_t pc;
   word_t pc4;
   word_t pc_next;

   assign pc4         = pc + 32'd4;
   assign imem_addr_o = pc;          // imem read is combinational

   // branch beats jump beats stall
   always_comb begin
      if (ctl.branch_take)     pc_next = ctl.branch_pc;
      else if (ctl.jump_take)  pc_next = ctl.jump_pc;
      else if (ctl.load_stall) pc_next = pc;   // refetch same word
      else                     pc_next = pc4;
   end

   always_ff @(posedge CLK) begin
      if (rst_i) pc <= PC_INIT;
      else       pc <= pc_next;
   end

   assign ifid_o.instr = imem_load_i;
   assign ifid_o.pc4   = pc4;

   // front latch control
   assign ifid_flush_o = ctl.branch_take | ctl.jump_take;
   assign ifid_hold_o  = ctl.load_stall & ~ifid_flush_o;
   assign idex_flush_o = ctl.branch_take | ctl.load_stall;  // kill or bubble

endmodule

//--- source/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import cpu_pkg::*; (
   input  idex_t       idex_i,
   input  regbits_t    ifid_rs_i,
   input  regbits_t    ifid_rt_i,
   input  logic        mem_regw_i,
   input  regbits_t    mem_dest_i,
   input  logic        wb_regw_i,
   input  regbits_t    wb_dest_i,
   pipe_ctl_if.hazard  ctl,
   output fwd_sel_t    sel_a_o,
   output fwd_sel_t    sel_b_o
);

   // nearest producer wins, r0 never forwards
   function automatic fwd_sel_t pick_src(input regbits_t src,
                                         input logic mem_regw, input regbits_t mem_dest,
                                         input logic wb_regw, input regbits_t wb_dest);
      if (mem_regw && (mem_dest != '0) && (mem_dest == src))  return FWD_MEM;
      else if (wb_regw && (wb_dest != '0) && (wb_dest == src)) return FWD_WB;
      else                                                     return FWD_REG;
   endfunction

   assign sel_a_o = pick_src(idex_i.rs, mem_regw_i, mem_dest_i, wb_regw_i, wb_dest_i);
   assign sel_b_o = pick_src(idex_i.rt, mem_regw_i, mem_dest_i, wb_regw_i, wb_dest_i);

   // load in execute feeding the word in decode
   assign ctl.load_stall = idex_i.ctrl.mem_read &&
                           ((idex_i.rt == ifid_rs_i) || (idex_i.rt == ifid_rt_i));

endmodule

//--- source/mem_access.sv
`timescale 1ns/1ps

module mem_access import cpu_pkg::*; (
   input  logic     CLK,
   input  logic     rst_i,
   input  exmem_t   exmem_i,
   output word_t    dmem_addr_o,
   output word_t    dmem_store_o,
   output logic     dmem_ren_o,
   output logic     dmem_wen_o,
   input  word_t    dmem_load_i,
   output logic     wb_regw_o,
   output regbits_t wb_dest_o,
   output word_t    wb_data_o,
   output logic     halt_o
);

   logic  wb_load;     // wb picks load data
   word_t wb_result;
   word_t wb_loaded;

   // dmem driven straight from ex/mem
   assign dmem_addr_o  = exmem_i.result;
   assign dmem_store_o = exmem_i.store;
   assign dmem_ren_o   = exmem_i.mem_read;
   assign dmem_wen_o   = exmem_i.mem_write;   // write lands at this edge

   ////////////////////////////////////////
   // mem/wb register
   ////////////////////////////////////////
   always_ff @(posedge CLK) begin
      if (rst_i) begin
         wb_regw_o <= 1'b0;
         wb_load   <= 1'b0;
         halt_o    <= 1'b0;
      end else begin
         wb_regw_o <= exmem_i.regw;
         wb_load   <= exmem_i.mem_read;
         if (exmem_i.halt) halt_o <= 1'b1;    // sticky till reset
      end
   end

   always_ff @(posedge CLK) begin
      wb_dest_o <= exmem_i.dest;
      wb_result <= exmem_i.result;
      wb_loaded <= dmem_load_i;
   end

   assign wb_data_o = wb_load ? wb_loaded : wb_result;

endmodule

//--- source/pipe_ctl_if.sv
`timescale 1ns/1ps

// stall and redirect levels, all valid within the cycle
interface pipe_ctl_if import cpu_pkg::*; ();

   logic  load_stall;   // load-use bubble
   logic  jump_take;    // j in decode
   word_t jump_pc;
   logic  branch_take;  // taken beq/bne in execute
   word_t branch_pc;

   modport fetch   (input load_stall, jump_take, jump_pc, branch_take, branch_pc);
   modport hazard  (output load_stall);
   modport decode  (output jump_take, jump_pc);
   modport execute (output branch_take, branch_pc);

endinterface

//--- source/pipe_latch.sv
`timescale 1ns/1ps

module pipe_latch #(
   parameter type payload_t = logic [31:0],
   parameter bit  CAN_HOLD  = 1'b1,
   parameter bit  CAN_FLUSH = 1'b1
) (
   input  logic     CLK,
   input  logic     rst_i,
   input  logic     hold_i,    // ignored unless CAN_HOLD
   input  logic     flush_i,   // ignored unless CAN_FLUSH
   input  payload_t d_i,
   output payload_t q_o
);

   logic clr;
   logic keep;

   assign clr  = rst_i | (CAN_FLUSH & flush_i);
   assign keep = CAN_HOLD & hold_i;

   // zero payload decodes as a no-op
   always_ff @(posedge CLK) begin
      if (clr)        q_o <= '0;
      else if (!keep) q_o <= d_i;
   end

endmodule
